/* verilog.f */
+incdir+include
verilog/cid_pkg.sv
verilog/http_token_dfa.sv
verilog/stream_context.sv
verilog/packet_sequencer.sv
verilog/scan_regs.sv
verilog/content_scanner.sv
test/content_scanner_checker.sv
test/content_scanner_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --assert --timing -Wno-fatal -f verilog.f \
   --top-module content_scanner_tb -o content_scanner_sim || exit 1
./obj_dir/content_scanner_sim +verilator+error+limit+100 2>&1 | tee /dev/stderr \
   | grep "TEST PASSED" > /dev/null && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* test/content_scanner_tb.sv */
`timescale 1ns/100ps
`include "cid_config.svh"

module content_scanner_tb
   import cid_pkg::*;
();

   localparam int half_period = 50;
   localparam int n_random = 300;
   localparam int n_directed = 8;
   localparam int n_packets = n_random + n_directed;
   localparam int watchdog_cycles = n_packets * 20 + 200;
   // Token letters, lower case
   localparam logic [39:0] token = "http/";

   logic          clk;
   logic          rst_n;
   pkt_byte_t     pkt_in;
   wb_req_t       wb_req;
   wb_rsp_t       wb_rsp;
   scan_verdict_t verdict;
   logic          fired;

   // Reference model state
   int                      saved_state [0:`CID_STREAMS-1];
   logic [`CID_STREAMS-1:0] known_m = '0;
   logic [`CID_STREAMS-1:0] mask_m = '0;
   logic [`CID_CNT_W-1:0]   count_m = '0;
   scan_verdict_t           exp_q [$];
   int unsigned             due_q [$];
   int unsigned             cycle = 0;
   logic [31:0]             rng = 32'h115d;
   logic [7:0]              pkt_buf [0:15];
   // Small stream set spread over both mask halves
   logic [`CID_SID_W-1:0]   stream_set [0:7] = '{6'd0, 6'd5, 6'd17, 6'd31,
                                                 6'd32, 6'd40, 6'd58, 6'd63};

   content_scanner content_scanner_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .pkt_in  (pkt_in),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .verdict (verdict),
      .fired   (fired)
   );

   bind content_scanner content_scanner_checker content_scanner_checker_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .pkt_in  (pkt_in),
      .wb_rsp  (wb_rsp),
      .verdict (verdict),
      .fired   (fired)
   );

   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic value_error(input string msg);
      stop_run($sformatf("FAIL %0t: %s", $time, msg));
   endtask

   task automatic check_verdict(input scan_verdict_t got, input scan_verdict_t exp);
      if (got !== exp)
         value_error($sformatf("verdict stream %0d matched %b counted %b, expected %0d %b %b",
            got.stream_id, got.matched, got.counted, exp.stream_id, exp.matched,
            exp.counted));
   endtask

   task automatic check_word(input wb_rsp_t rsp, input logic [`CID_DAT_W-1:0] exp,
                             input string what);
      if (rsp.dat !== exp)
         value_error($sformatf("%s read %h, expected %h", what, rsp.dat, exp));
   endtask

   task automatic check_fired(input logic got, input logic exp);
      if (got !== exp)
         value_error($sformatf("fired is %b, expected %b", got, exp));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] rand32();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Letter expected after s matched characters
   function automatic logic [7:0] token_char(input int s);
      return token[8*(4-s) +: 8];
   endfunction

   // Token rule, case-insensitive, an H restarts at 1
   function automatic int dfa_next(input int s, input logic [7:0] ch);
      logic [7:0] lc;
      lc = (ch >= "A" && ch <= "Z") ? ch + 8'd32 : ch;
      if (lc == token_char(s))
         return s + 1;
      else if (lc == "h")
         return 1;
      return 0;
   endfunction

   // Mostly the next token letter, sometimes another letter or noise
   function automatic logic [7:0] pick_byte(input int st);
      logic [31:0] r;
      logic [7:0]  ch;
      r = rand32();
      if (r[1:0] != 2'd0)
         ch = token_char(st);
      else if (r[2])
         ch = token_char(int'(r[10:8]) % 5);
      else
         ch = r[23:16];
      if (r[5] && ch >= "a" && ch <= "z")
         ch = ch - 8'd32;
      return ch;
   endfunction

   task automatic bus_cycle(input logic we, input logic [`CID_ADR_W-1:0] adr,
                            input logic [`CID_DAT_W-1:0] dat, output wb_rsp_t rsp);
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      // Hold the request until ack
      @(negedge clk);
      while (!wb_rsp.ack)
         @(negedge clk);
      rsp = wb_rsp;
      wb_req = '0;
      @(negedge clk);
      if (wb_rsp.ack)
         stop_run("Wishbone slave gave a second ack for one access");
   endtask

   task automatic write_reg(input logic [`CID_ADR_W-1:0] adr, input logic [`CID_DAT_W-1:0] dat);
      wb_rsp_t rsp;
      bus_cycle(1'b1, adr, dat, rsp);
      case (adr)
         `CID_REG_EN_LO: mask_m[31:0] = dat;
         `CID_REG_EN_HI: mask_m[63:32] = dat;
         `CID_REG_COUNT: count_m = '0;
         `CID_REG_FORGET: known_m = '0;
         default: ;
      endcase
   endtask

   task automatic read_reg(input logic [`CID_ADR_W-1:0] adr, output wb_rsp_t rsp);
      bus_cycle(1'b0, adr, '0, rsp);
   endtask

   // New mask, then read both halves back
   task automatic write_mask(input logic [31:0] lo, input logic [31:0] hi);
      wb_rsp_t rsp;
      write_reg(`CID_REG_EN_LO, lo);
      write_reg(`CID_REG_EN_HI, hi);
      read_reg(`CID_REG_EN_LO, rsp);
      check_word(rsp, mask_m[31:0], "EN_LO");
      read_reg(`CID_REG_EN_HI, rsp);
      check_word(rsp, mask_m[63:32], "EN_HI");
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0)
         @(negedge clk);
   endtask

   task automatic verify_count();
      wb_rsp_t rsp;
      wait_drained();
      read_reg(`CID_REG_COUNT, rsp);
      check_word(rsp, {{(`CID_DAT_W-`CID_CNT_W){1'b0}}, count_m}, "COUNT");
   endtask

   // One packet, then 3 idle cycles, model updated as it goes
   task automatic send_packet(input logic [`CID_SID_W-1:0] sid, input int len, input bit fill);
      scan_verdict_t exp;
      int            st;
      logic          hit;
      logic [7:0]    ch;
      if (!known_m[sid])
      begin
         saved_state[sid] = 0;
         known_m[sid] = 1'b1;
      end
      st = saved_state[sid];
      hit = 1'b0;
      for (int i = 0; i < len; i++)
      begin
         ch = fill ? pick_byte(st) : pkt_buf[i];
         st = dfa_next(st, ch);
         if (st == 5)
         begin
            hit = 1'b1;
            st = 0;
         end
         @(negedge clk);
         pkt_in.valid     = 1'b1;
         pkt_in.sop       = (i == 0);
         pkt_in.eop       = (i == len - 1);
         pkt_in.stream_id = sid;
         pkt_in.data      = ch;
      end
      exp.valid     = 1'b1;
      exp.stream_id = sid;
      exp.matched   = hit;
      exp.counted   = hit && mask_m[sid];
      exp_q.push_back(exp);
      due_q.push_back(cycle + 4);
      // Only enabled streams carry state to their next packet
      if (mask_m[sid])
         saved_state[sid] = st;
      if (exp.counted)
         count_m++;
      repeat (3)
      begin
         @(negedge clk);
         pkt_in = '0;
      end
   endtask

   task automatic send_text(input logic [`CID_SID_W-1:0] sid, input string text);
      for (int i = 0; i < text.len(); i++)
         pkt_buf[i] = text[i];
      send_packet(sid, text.len(), 1'b0);
   endtask

   // Verdicts and live flag, sampled away from the rising edge
   always @(negedge clk)
   begin
      if (content_scanner_i.content_scanner_checker_i.assert_fails != 0)
         stop_run("An assertion of the bound checker failed");
      if (rst_n && verdict.valid)
      begin
         if (exp_q.size() == 0)
            stop_run("A verdict came out with no packet outstanding");
         else
         begin
            check_verdict(verdict, exp_q[0]);
            check_fired(fired, exp_q[0].matched);
            if (cycle != due_q[0])
               value_error($sformatf("verdict at cycle %0d, expected cycle %0d",
                  cycle, due_q[0]));
            exp_q.delete(0);
            due_q.delete(0);
         end
      end
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      stop_run($sformatf("Watchdog expired after %0d clock periods", watchdog_cycles));
   end

   initial
   begin
      logic [31:0] r;
      pkt_in = '0;
      wb_req = '0;
      rst_n  = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      // Streams 0, 5, 17, 31, 32 and 40 on, 58 and 63 off
      write_mask(32'h8002_0021, 32'h0000_0101);
      // Token split across two packets of one stream
      send_text(6'd5, "xxHT");
      send_text(6'd5, "tP/yy");
      // H restart and case mixing
      send_text(6'd0, "aHHTTP/");
      send_text(6'd40, "hTtP/");
      // Disabled stream carries no state
      send_text(6'd58, "hTt");
      send_text(6'd58, "p/");
      // Forget drops the partial token
      send_text(6'd17, "htt");
      wait_drained();
      write_reg(`CID_REG_FORGET, '0);
      send_text(6'd17, "p/");
      verify_count();
      write_reg(`CID_REG_COUNT, '0);
      verify_count();
      for (int n = 0; n < n_random; n++)
      begin
         r = rand32();
         send_packet(stream_set[r[2:0]], 1 + int'(r[15:8]) % 12, 1'b1);
         // Register traffic now and then, on an idle pipeline
         if (n % 25 == 24)
         begin
            verify_count();
            r = rand32();
            case (r[1:0])
               2'd0:
               begin
                  write_reg(`CID_REG_COUNT, '0);
                  verify_count();
               end
               2'd1: write_reg(`CID_REG_FORGET, '0);
               2'd2: write_mask(rand32(), rand32());
               default: ;
            endcase
         end
      end
      verify_count();
      $display("TEST PASSED");
      $finish;
   end

endmodule

/* test/content_scanner_checker.sv */
`timescale 1ns/100ps

module content_scanner_checker
   import cid_pkg::*;
(
   input logic          clk,
   input logic          rst_n,
   input pkt_byte_t     pkt_in,
   input wb_rsp_t       wb_rsp,
   input scan_verdict_t verdict,
   input logic          fired
);

   // Number of failed assertions so far
   int unsigned assert_fails = 0;

   logic eop_in;
   logic sop_in;

   assign eop_in = pkt_in.valid && pkt_in.eop;
   assign sop_in = pkt_in.valid && pkt_in.sop;

   // Ack lasts one cycle only
   ack_single: assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |-> !$past(wb_rsp.ack))
   else
   begin
      $error("Wishbone ack held for two cycles");
      assert_fails++;
   end

   // Verdict comes exactly 4 cycles after the eop byte, never otherwise
   verdict_delay: assert property (@(posedge clk) disable iff (!rst_n)
      verdict.valid == $past(eop_in, 4))
   else
   begin
      $error("verdict not 4 cycles after eop");
      assert_fails++;
   end

   // Two idle cycles at least between eop and the next sop
   sop_gap: assert property (@(posedge clk) disable iff (!rst_n)
      sop_in |-> !$past(eop_in, 1) && !$past(eop_in, 2))
   else
   begin
      $error("sop within 2 cycles of an eop");
      assert_fails++;
   end

   // No live flag after a packet without a match
   fired_low: assert property (@(posedge clk) disable iff (!rst_n)
      $past(verdict.valid && !verdict.matched) |-> !fired)
   else
   begin
      $error("fired high after an unmatched verdict");
      assert_fails++;
   end

endmodule

/* verilog/content_scanner.sv */
`timescale 1ns/100ps
`include "cid_config.svh"

module content_scanner
   import cid_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  pkt_byte_t     pkt_in,
   input  wb_req_t       wb_req,
   output wb_rsp_t       wb_rsp,
   output scan_verdict_t verdict,
   output logic          fired
);

   scan_ctl_t               ctl_s1;
   logic [`CID_STREAMS-1:0] enable_mask;
   logic [`CID_CNT_W-1:0]   count;
   logic                    count_clear;
   logic                    forget;

   // Input stage, stream lookup and enable
   packet_sequencer packet_sequencer_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .pkt_in      (pkt_in),
      .enable_mask (enable_mask),
      .forget      (forget),
      .ctl_s1      (ctl_s1)
   );

   // State memory, DFA and packet verdict
   stream_context stream_context_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .ctl_s1      (ctl_s1),
      .count_clear (count_clear),
      .count       (count),
      .verdict     (verdict),
      .fired       (fired)
   );

   // Wishbone register slave
   scan_regs scan_regs_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .wb_req      (wb_req),
      .count       (count),
      .wb_rsp      (wb_rsp),
      .enable_mask (enable_mask),
      .count_clear (count_clear),
      .forget      (forget)
   );

endmodule

/* verilog/scan_regs.sv */
`timescale 1ns/100ps
`include "cid_config.svh"

module scan_regs
   import cid_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  wb_req_t                wb_req,
   input  logic [`CID_CNT_W-1:0]  count,
   output wb_rsp_t                wb_rsp,
   output logic [`CID_STREAMS-1:0] enable_mask,
   output logic                   count_clear,
   output logic                   forget
);

   logic                  take;
   logic                  wr;
   logic                  ack_q;
   logic [`CID_DAT_W-1:0] rd_dat;

   // New cycle seen, ack not yet given
   assign take = wb_req.cyc && wb_req.stb && !ack_q;
   assign wr   = take && wb_req.we;

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = rd_dat;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ack_q       <= 1'b0;
         enable_mask <= '0;
         count_clear <= 1'b0;
         forget      <= 1'b0;
      end
      else
      begin
         // Single-cycle ack, dropped even if stb stays up
         ack_q <= take;
         // Pulses for one cycle on the accepted write
         count_clear <= wr && (wb_req.adr == `CID_REG_COUNT);
         forget      <= wr && (wb_req.adr == `CID_REG_FORGET);
         if (wr && wb_req.adr == `CID_REG_EN_LO)
            enable_mask[31:0] <= wb_req.dat;
         if (wr && wb_req.adr == `CID_REG_EN_HI)
            enable_mask[63:32] <= wb_req.dat;
      end
   end

   // Read data, valid together with ack
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         case (wb_req.adr)
            `CID_REG_EN_LO: rd_dat <= enable_mask[31:0];
            `CID_REG_EN_HI: rd_dat <= enable_mask[63:32];
            // Counter zero-extended to the bus width
            `CID_REG_COUNT: rd_dat <= {{(`CID_DAT_W-`CID_CNT_W){1'b0}}, count};
            default: rd_dat <= '0;
         endcase
      end
   end

endmodule

/* verilog/packet_sequencer.sv */
`timescale 1ns/100ps
`include "cid_config.svh"

module packet_sequencer
   import cid_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  pkt_byte_t              pkt_in,
   input  logic [`CID_STREAMS-1:0] enable_mask,
   input  logic                   forget,
   output scan_ctl_t              ctl_s1
);

   // One bit per stream, set once a packet of it has been seen
   logic [`CID_STREAMS-1:0] known;
   logic                    start;

   assign start = pkt_in.valid && pkt_in.sop;

   // Known-stream table
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         known <= '0;
      // Forget wins over a packet start in the same cycle
      else if (forget)
         known <= '0;
      else if (start)
         known[pkt_in.stream_id] <= 1'b1;
   end

   // Stage 1 control word
   always_ff @(posedge clk)
   begin
      ctl_s1.stream_id <= pkt_in.stream_id;
      ctl_s1.data      <= pkt_in.data;
      // Table lookup before this packet marks the stream
      ctl_s1.new_stream <= !known[pkt_in.stream_id];
      ctl_s1.enable     <= enable_mask[pkt_in.stream_id];
      if (!rst_n)
      begin
         ctl_s1.valid      <= 1'b0;
         ctl_s1.load_state <= 1'b0;
         ctl_s1.eop        <= 1'b0;
      end
      else
      begin
         ctl_s1.valid      <= pkt_in.valid;
         // sop byte makes the context restore the stream state
         ctl_s1.load_state <= start;
         ctl_s1.eop        <= pkt_in.valid && pkt_in.eop;
      end
   end

endmodule

/* verilog/stream_context.sv */
`timescale 1ns/100ps
`include "cid_config.svh"

module stream_context
   import cid_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  scan_ctl_t            ctl_s1,
   input  logic                 count_clear,
   output logic [`CID_CNT_W-1:0] count,
   output scan_verdict_t        verdict,
   output logic                 fired
);

   // Saved DFA state, one entry per stream
   dfa_state_t state_mem [0:`CID_STREAMS-1];

   scan_ctl_t  ctl_s2;
   scan_ctl_t  ctl_s3;
   dfa_state_t state_in;
   logic       state_in_vld;
   dfa_state_t state_out;
   logic       accept;
   logic       match_flag;
   logic       pkt_hit;

   // Restore point for the DFA, lined up with the byte in stage 2
   always_ff @(posedge clk)
   begin
      ctl_s2   <= ctl_s1;
      state_in <= ctl_s1.new_stream ? '0 : state_mem[ctl_s1.stream_id];
      if (!rst_n)
      begin
         ctl_s2.valid <= 1'b0;
         state_in_vld <= 1'b0;
      end
      else
         state_in_vld <= ctl_s1.valid && ctl_s1.load_state;
   end

   http_token_dfa http_token_dfa_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (ctl_s2.data),
      .char_vld     (ctl_s2.valid),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

   // Stage 3 control sits beside the DFA result
   always_ff @(posedge clk)
   begin
      ctl_s3 <= ctl_s2;
      if (!rst_n)
         ctl_s3.valid <= 1'b0;
   end

   // Packet flag so far, the previous packet's flag is dropped on sop
   assign pkt_hit = (match_flag && !ctl_s3.load_state) || accept;
   assign fired   = match_flag;

   // One write port
   // eop save of an enabled stream first, else zero for a newly seen stream
   always_ff @(posedge clk)
   begin
      if (ctl_s3.valid && ctl_s3.eop && ctl_s3.enable)
         state_mem[ctl_s3.stream_id] <= state_out;
      else if (ctl_s1.valid && ctl_s1.load_state && ctl_s1.new_stream)
         state_mem[ctl_s1.stream_id] <= '0;
   end

   always_ff @(posedge clk)
   begin
      verdict.stream_id <= ctl_s3.stream_id;
      verdict.matched   <= pkt_hit;
      verdict.counted   <= pkt_hit && ctl_s3.enable;
      if (!rst_n)
      begin
         match_flag    <= 1'b0;
         count         <= '0;
         verdict.valid <= 1'b0;
      end
      else
      begin
         if (ctl_s3.valid)
            match_flag <= pkt_hit;
         verdict.valid <= ctl_s3.valid && ctl_s3.eop;
         // Register clear beats a same-cycle increment
         if (count_clear)
            count <= '0;
         else if (ctl_s3.valid && ctl_s3.eop && ctl_s3.enable && pkt_hit)
            count <= count + 1'b1;
      end
   end

endmodule

/* verilog/http_token_dfa.sv */
`timescale 1ns/100ps

module http_token_dfa
   import cid_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] char_in,
   input  logic       char_vld,
   input  dfa_state_t state_in,
   input  logic       state_in_vld,
   output dfa_state_t state_out,
   output logic       accept
);

   // Full token seen
   localparam dfa_state_t accept_state = 3'd5;

   dfa_state_t cur_state;
   dfa_state_t next_state;
   logic [7:0] folded;
   logic [7:0] want;

   always_comb
   begin
      // Loaded state takes over from the running one at packet start
      cur_state = state_in_vld ? state_in : state_out;
      // Fold upper case letters to lower case, '/' passes unchanged
      folded = (char_in >= "A" && char_in <= "Z") ? (char_in | 8'h20) : char_in;
      // Next expected letter of "http/"
      case (cur_state)
         3'd0: want = "h";
         3'd1: want = "t";
         3'd2: want = "t";
         3'd3: want = "p";
         default: want = "/";
      endcase
      if (folded == want)
         next_state = cur_state + 3'd1;
      // An H after a partial match may begin a new token
      else if (folded == "h")
         next_state = 3'd1;
      else
         next_state = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out <= '0;
         accept    <= 1'b0;
      end
      else
      begin
         accept <= 1'b0;
         if (char_vld)
         begin
            // Report the hit and restart the search
            if (next_state == accept_state)
            begin
               state_out <= '0;
               accept    <= 1'b1;
            end
            else
               state_out <= next_state;
         end
      end
   end

endmodule

/* verilog/cid_pkg.sv */
`include "cid_config.svh"

package cid_pkg;

   // One DFA state, n = characters of the token seen so far
   typedef logic [`CID_STATE_W-1:0] dfa_state_t;

   // Byte as it arrives from the packet interface
   typedef struct packed {
      logic                  valid;
      logic                  sop;
      logic                  eop;
      logic [`CID_SID_W-1:0] stream_id;
      logic [7:0]            data;
   } pkt_byte_t;

   // Control word that follows each byte down the pipeline
   typedef struct packed {
      logic                  valid;
      logic                  load_state;
      logic                  new_stream;
      logic                  enable;
      logic                  eop;
      logic [`CID_SID_W-1:0] stream_id;
      logic [7:0]            data;
   } scan_ctl_t;

   // Result for one finished packet
   typedef struct packed {
      logic                  valid;
      logic [`CID_SID_W-1:0] stream_id;
      logic                  matched;
      logic                  counted;
   } scan_verdict_t;

   // Wishbone classic request and response
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`CID_ADR_W-1:0] adr;
      logic [`CID_DAT_W-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic                  ack;
      logic [`CID_DAT_W-1:0] dat;
   } wb_rsp_t;

endpackage

/* include/cid_config.svh */
`ifndef CID_CONFIG_SVH
`define CID_CONFIG_SVH

// Stream id space
`define CID_STREAMS 64
`define CID_SID_W 6

// DFA state holds 0 to 5 matched characters
`define CID_STATE_W 3

// Match counter width
`define CID_CNT_W 16

// Wishbone address and data widths
`define CID_ADR_W 4
`define CID_DAT_W 32

// Register word addresses
`define CID_REG_EN_LO 4'd0
`define CID_REG_EN_HI 4'd1
`define CID_REG_COUNT 4'd2
`define CID_REG_FORGET 4'd3

`endif
